// File: project.f
+incdir+source
source/mem_pipe_pkg.sv
source/mem_request_gen.sv
source/stage_reg.sv
source/mem_stage.sv
source/mem_access_path.sv
testbench/mem_access_path_asserts.sv
testbench/tb_mem_access_path.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_mem_access_path \
    -f project.f \
    -o sim_mem_access_path
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_mem_access_path)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1

// File: source/mem_access_path.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_path (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      advance_i,
    input  logic                      flush_i,
    input  logic                      issue_i,
    input  logic                      is_load_i,
    input  logic                      is_store_i,
    input  mem_pipe_pkg::funct3_t     funct3_i,
    input  mem_pipe_pkg::word_t       addr_i,
    input  mem_pipe_pkg::word_t       store_data_i,
    input  mem_pipe_pkg::reg_addr_t   rd_i,
    input  mem_pipe_pkg::word_t       dmem_rdata_i,
    output mem_pipe_pkg::word_t       dmem_addr_o,
    output mem_pipe_pkg::word_t       dmem_wdata_o,
    output mem_pipe_pkg::mask_t       dmem_rmask_o,
    output mem_pipe_pkg::mask_t       dmem_wmask_o,
    output logic                      wb_valid_o,
    output logic                      wb_load_o,
    output logic                      wb_trap_o,
    output mem_pipe_pkg::reg_addr_t   wb_rd_o,
    output mem_pipe_pkg::order_t      wb_order_o,
    output mem_pipe_pkg::word_t       wb_data_o
);

    logic                   accept;
    mem_pipe_pkg::access_t  req;
    logic                   acc_valid;
    mem_pipe_pkg::access_t  acc_q;
    mem_pipe_pkg::wb_t      wb_d;
    mem_pipe_pkg::wb_t      wb_q;

    mem_request_gen u_req_gen (
        .clk          (clk),
        .rst          (rst),
        .advance_i    (advance_i),
        .issue_i      (issue_i),
        .is_load_i    (is_load_i),
        .is_store_i   (is_store_i),
        .funct3_i     (funct3_i),
        .addr_i       (addr_i),
        .store_data_i (store_data_i),
        .rd_i         (rd_i),
        .accept_o     (accept),
        .req_o        (req)
    );

    stage_reg #(.payload_t(mem_pipe_pkg::access_t)) u_access_stage (
        .clk       (clk),
        .rst       (rst),
        .advance_i (advance_i),
        .flush_i   (flush_i),
        .valid_i   (accept),
        .data_i    (req),
        .valid_o   (acc_valid),
        .data_o    (acc_q)
    );

    mem_stage u_mem_stage (
        .valid_i      (acc_valid),
        .req_i        (acc_q),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_rmask_o (dmem_rmask_o),
        .dmem_wmask_o (dmem_wmask_o),
        .wb_o         (wb_d)
    );

    stage_reg #(.payload_t(mem_pipe_pkg::wb_t)) u_wb_stage (
        .clk       (clk),
        .rst       (rst),
        .advance_i (advance_i),
        .flush_i   (1'b0),          // only the access stage is flushed
        .valid_i   (acc_valid),
        .data_i    (wb_d),
        .valid_o   (wb_valid_o),
        .data_o    (wb_q)
    );

    assign wb_load_o  = wb_q.is_load;
    assign wb_trap_o  = wb_q.trap;
    assign wb_rd_o    = wb_q.rd;
    assign wb_order_o = wb_q.order;
    assign wb_data_o  = wb_q.data;

endmodule

`default_nettype wire

// File: source/mem_pipe_consts.svh
`ifndef MEM_PIPE_CONSTS_SVH
`define MEM_PIPE_CONSTS_SVH

// datapath widths
`define MP_XLEN     32
`define MP_ORDER_W  64
`define MP_REG_W    5
`define MP_BYTES    4

// load size codes
`define MP_F3_LB    3'b000
`define MP_F3_LH    3'b001
`define MP_F3_LW    3'b010
`define MP_F3_LBU   3'b100
`define MP_F3_LHU   3'b101

// store size codes
`define MP_F3_SB    3'b000
`define MP_F3_SH    3'b001
`define MP_F3_SW    3'b010

`endif

// File: source/mem_pipe_pkg.sv
`default_nettype none

`include "mem_pipe_consts.svh"

package mem_pipe_pkg;

    typedef logic [`MP_XLEN-1:0]            word_t;
    typedef logic [`MP_BYTES-1:0]           mask_t;
    typedef logic [`MP_ORDER_W-1:0]         order_t;
    typedef logic [`MP_REG_W-1:0]           reg_addr_t;
    typedef logic [2:0]                     funct3_t;
    typedef logic [$clog2(`MP_BYTES)-1:0]   offset_t;   // byte lane within a word

    // request as it sits in the access stage
    typedef struct packed {
        word_t      addr;       // word aligned
        word_t      wdata;      // already lane shifted
        mask_t      rmask;
        mask_t      wmask;
        offset_t    offset;
        funct3_t    funct3;
        logic       is_load;
        logic       trap;
        reg_addr_t  rd;
        order_t     order;
    } access_t;

    // result as it sits in the writeback stage
    typedef struct packed {
        word_t      data;       // extended load value
        logic       is_load;
        logic       trap;
        reg_addr_t  rd;
        order_t     order;
    } wb_t;

endpackage

`default_nettype wire

// File: source/mem_request_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_pipe_consts.svh"

module mem_request_gen (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      advance_i,
    input  logic                      issue_i,
    input  logic                      is_load_i,
    input  logic                      is_store_i,
    input  mem_pipe_pkg::funct3_t     funct3_i,
    input  mem_pipe_pkg::word_t       addr_i,
    input  mem_pipe_pkg::word_t       store_data_i,
    input  mem_pipe_pkg::reg_addr_t   rd_i,
    output logic                      accept_o,
    output mem_pipe_pkg::access_t     req_o
);

    mem_pipe_pkg::order_t   order_q;
    mem_pipe_pkg::offset_t  offset;
    mem_pipe_pkg::offset_t  lane;       // zero for word accesses
    mem_pipe_pkg::mask_t    size_mask;  // mask before the lane shift
    logic                   size_ok;
    logic                   is_word;

    assign accept_o = issue_i & advance_i;
    assign offset   = addr_i[$clog2(`MP_BYTES)-1:0];
    assign lane     = is_word ? '0 : offset;

    // loads take priority over stores in the size decode
    always_comb begin
        size_mask = '0;
        size_ok   = 1'b0;
        is_word   = 1'b0;
        if (is_load_i) begin
            case (funct3_i)
                `MP_F3_LB, `MP_F3_LBU: size_mask = 4'b0001;
                `MP_F3_LH, `MP_F3_LHU: size_mask = 4'b0011;
                `MP_F3_LW:             size_mask = 4'b1111;
                default:               size_mask = '0;
            endcase
        end else if (is_store_i) begin
            case (funct3_i)
                `MP_F3_SB: size_mask = 4'b0001;
                `MP_F3_SH: size_mask = 4'b0011;
                `MP_F3_SW: size_mask = 4'b1111;
                default:   size_mask = '0;
            endcase
        end
        size_ok = (size_mask != '0);
        is_word = (size_mask == 4'b1111);
    end

    always_comb begin
        req_o         = '0;
        req_o.addr    = addr_i & ~mem_pipe_pkg::word_t'(`MP_BYTES - 1);
        req_o.wdata   = store_data_i << (8 * lane);
        req_o.offset  = offset;
        req_o.funct3  = funct3_i;
        req_o.is_load = is_load_i;
        req_o.trap    = (is_load_i | is_store_i) & ~size_ok;
        req_o.rd      = rd_i;
        req_o.order   = order_q + mem_pipe_pkg::order_t'(1);  // next number in line
        if (is_load_i) begin
            req_o.rmask = size_mask << lane;
        end else if (is_store_i) begin
            req_o.wmask = size_mask << lane;
        end
    end

    // commit order starts at all ones so the first item is 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            order_q <= '1;
        end else if (accept_o) begin
            order_q <= order_q + mem_pipe_pkg::order_t'(1);
        end
    end

endmodule

`default_nettype wire

// File: source/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_pipe_consts.svh"

module mem_stage (
    input  logic                    valid_i,
    input  mem_pipe_pkg::access_t   req_i,
    input  mem_pipe_pkg::word_t     dmem_rdata_i,
    output mem_pipe_pkg::word_t     dmem_addr_o,
    output mem_pipe_pkg::word_t     dmem_wdata_o,
    output mem_pipe_pkg::mask_t     dmem_rmask_o,
    output mem_pipe_pkg::mask_t     dmem_wmask_o,
    output mem_pipe_pkg::wb_t       wb_o
);

    mem_pipe_pkg::word_t lane_data;

    assign dmem_addr_o  = req_i.addr;
    assign dmem_wdata_o = req_i.wdata;
    assign dmem_rmask_o = valid_i ? req_i.rmask : '0;   // no access for a bubble
    assign dmem_wmask_o = valid_i ? req_i.wmask : '0;

    assign lane_data = dmem_rdata_i >> (8 * req_i.offset);

    always_comb begin
        wb_o         = '0;
        wb_o.is_load = req_i.is_load;
        wb_o.trap    = req_i.trap;
        wb_o.rd      = req_i.rd;
        wb_o.order   = req_i.order;
        if (req_i.is_load && !req_i.trap) begin
            case (req_i.funct3)
                `MP_F3_LB:  wb_o.data = {{(`MP_XLEN-8){lane_data[7]}}, lane_data[7:0]};
                `MP_F3_LBU: wb_o.data = {{(`MP_XLEN-8){1'b0}}, lane_data[7:0]};
                `MP_F3_LH:  wb_o.data = {{(`MP_XLEN-16){lane_data[15]}}, lane_data[15:0]};
                `MP_F3_LHU: wb_o.data = {{(`MP_XLEN-16){1'b0}}, lane_data[15:0]};
                `MP_F3_LW:  wb_o.data = lane_data;
                default:    wb_o.data = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     advance_i,
    input  logic     flush_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    // flush beats advance
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_o <= 1'b0;
        end else if (flush_i) begin
            valid_o <= 1'b0;
        end else if (advance_i) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            data_o <= data_i;   // holds while stalled
        end
    end

endmodule

`default_nettype wire

// File: testbench/mem_access_path_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_path_asserts (
    input logic                clk,
    input logic                rst,
    input logic                acc_valid_i,
    input mem_pipe_pkg::mask_t rmask_i,
    input mem_pipe_pkg::mask_t wmask_i,
    input logic                wb_valid_i
);

    // a bubble touches no byte lane
    mask_idle: assert property (@(posedge clk) disable iff (rst)
        !acc_valid_i |-> (rmask_i == '0 && wmask_i == '0))
        else $error("dmem mask driven while the access stage is empty");

    one_direction: assert property (@(posedge clk) disable iff (rst)
        !(rmask_i != '0 && wmask_i != '0))
        else $error("read and write masks active in the same cycle");

    // empty through reset and the first cycle after it
    wb_after_reset: assert property (@(posedge clk)
        (rst || $past(rst)) |-> !wb_valid_i)
        else $error("wb_valid_o set right after reset");

endmodule

`default_nettype wire

// File: testbench/tb_mem_access_path.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_pipe_consts.svh"

module tb_mem_access_path;

    localparam int ITEMS  = 28;
    localparam int CYCLES = 4 * ITEMS + 40;    // four cycles per item plus reset and stalls

    logic clk, rst, advance_i, flush_i, issue_i, is_load_i, is_store_i;
    logic wb_valid_o, wb_load_o, wb_trap_o;
    mem_pipe_pkg::funct3_t   funct3_i;
    mem_pipe_pkg::word_t     addr_i, store_data_i, dmem_rdata_i;
    mem_pipe_pkg::word_t     dmem_addr_o, dmem_wdata_o, wb_data_o;
    mem_pipe_pkg::mask_t     dmem_rmask_o, dmem_wmask_o;
    mem_pipe_pkg::reg_addr_t rd_i, wb_rd_o;
    mem_pipe_pkg::order_t    wb_order_o;

    mem_pipe_pkg::word_t  mem [16];
    logic [31:0]          lfsr_q = 32'h5425_fd08;
    mem_pipe_pkg::order_t exp_order;
    int                   mismatches;
    int                   failures;

    mem_access_path u_mem_access_path (.*);

    bind mem_access_path mem_access_path_asserts u_asserts (
        .clk         (clk),
        .rst         (rst),
        .acc_valid_i (acc_valid),
        .rmask_i     (dmem_rmask_o),
        .wmask_i     (dmem_wmask_o),
        .wb_valid_i  (wb_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic mem_pipe_pkg::word_t rand_bits(input int n);
        mem_pipe_pkg::word_t r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    // 16-word memory filled with random words during reset
    assign dmem_rdata_i = mem[dmem_addr_o[5:2]];

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                mem[i] <= rand_bits(32);
            end
        end else begin
            for (int b = 0; b < `MP_BYTES; b++) begin
                if (dmem_wmask_o[b]) begin
                    mem[dmem_addr_o[5:2]][8*b +: 8] <= dmem_wdata_o[8*b +: 8];
                end
            end
        end
    end

    function automatic mem_pipe_pkg::word_t pick_addr(input int idx, input int off);
        mem_pipe_pkg::word_t hi;
        hi = rand_bits(26);
        return {hi[25:0], 4'(idx), 2'(off)};
    endfunction

    function automatic logic funct3_legal(input logic ld, input mem_pipe_pkg::funct3_t f3);
        if (ld) begin
            return f3 inside {`MP_F3_LB, `MP_F3_LH, `MP_F3_LW, `MP_F3_LBU, `MP_F3_LHU};
        end
        return f3 inside {`MP_F3_SB, `MP_F3_SH, `MP_F3_SW};
    endfunction

    // low two funct3 bits give the size
    function automatic mem_pipe_pkg::mask_t lane_mask(input mem_pipe_pkg::funct3_t f3,
                                                      input logic [1:0] off);
        case (f3[1:0])
            2'b00:   return 4'b0001 << off;
            2'b01:   return 4'b0011 << off;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic mem_pipe_pkg::word_t extend_load(input mem_pipe_pkg::word_t w,
                                                        input mem_pipe_pkg::funct3_t f3,
                                                        input logic [1:0] off);
        mem_pipe_pkg::word_t s;
        s = w >> (8 * off);
        case (f3[1:0])
            2'b00:   s = f3[2] ? {24'h0, s[7:0]} : {{24{s[7]}}, s[7:0]};
            2'b01:   s = f3[2] ? {16'h0, s[15:0]} : {{16{s[15]}}, s[15:0]};
            default: s = s;
        endcase
        return s;
    endfunction

    task automatic word_equal(input string name, input mem_pipe_pkg::word_t got, exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic mask_equal(input string name, input mem_pipe_pkg::mask_t got, exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic order_equal(input string name, input mem_pipe_pkg::order_t got, exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic bit_equal(input string name, input logic got, exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic drive_item(input logic ld, st, input mem_pipe_pkg::funct3_t f3,
                              input mem_pipe_pkg::word_t addr, data,
                              input mem_pipe_pkg::reg_addr_t rd);
        issue_i      <= 1'b1;
        is_load_i    <= ld;
        is_store_i   <= st;
        funct3_i     <= f3;
        addr_i       <= addr;
        store_data_i <= data;
        rd_i         <= rd;
    endtask

    // one item through both stages with advance held high
    task automatic run_access(input logic ld, st, input mem_pipe_pkg::funct3_t f3,
                              input mem_pipe_pkg::word_t addr, data,
                              input mem_pipe_pkg::reg_addr_t rd);
        mem_pipe_pkg::word_t old;
        mem_pipe_pkg::word_t wr;
        mem_pipe_pkg::word_t bm;
        mem_pipe_pkg::mask_t m;
        logic ok;
        int   cycles;
        ok  = funct3_legal(ld, f3);
        m   = ok ? lane_mask(f3, addr[1:0]) : 4'b0000;
        wr  = data << (8 * addr[1:0]);
        bm  = {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
        old = mem[addr[5:2]];
        @(posedge clk);
        drive_item(ld, st, f3, addr, data, rd);
        @(posedge clk);
        issue_i <= 1'b0;
        @(negedge clk);
        word_equal("dmem_addr_o", dmem_addr_o, {addr[31:2], 2'b00});
        mask_equal("dmem_rmask_o", dmem_rmask_o, ld ? m : 4'b0000);
        mask_equal("dmem_wmask_o", dmem_wmask_o, (st && !ld) ? m : 4'b0000);
        if (st && !ld && ok)
            word_equal("dmem_wdata_o", dmem_wdata_o, wr);
        cycles = 0;
        while (!wb_valid_o && cycles < 4) begin
            @(negedge clk);
            cycles++;
        end
        if (!wb_valid_o) begin
            failures++;
            $display("Error at %0t: item with order %0d never reached writeback", $time, exp_order);
        end
        bit_equal("wb_load_o", wb_load_o, ld);
        bit_equal("wb_trap_o", wb_trap_o, (ld || st) && !ok);
        word_equal("wb_rd_o", 32'(wb_rd_o), 32'(rd));
        order_equal("wb_order_o", wb_order_o, exp_order);
        if (ld && ok)
            word_equal("wb_data_o", wb_data_o, extend_load(old, f3, addr[1:0]));
        if (st && !ld && ok)
            word_equal("memory word", mem[addr[5:2]], (old & ~bm) | (wr & bm));
        exp_order++;
    endtask

    task automatic stores_at_offsets();
        for (int o = 0; o < 4; o++)
            run_access(1'b0, 1'b1, `MP_F3_SB, pick_addr(o + 1, o), rand_bits(32), 5'(o + 1));
        for (int o = 0; o < 4; o += 2)
            run_access(1'b0, 1'b1, `MP_F3_SH, pick_addr(o + 5, o), rand_bits(32), 5'(o + 5));
        run_access(1'b0, 1'b1, `MP_F3_SW, pick_addr(9, 0), rand_bits(32), 5'd9);
    endtask

    task automatic loads_with_extension();
        for (int o = 0; o < 4; o++) begin
            run_access(1'b1, 1'b0, `MP_F3_LB, pick_addr(10 + o, o), '0, 5'(o + 10));
            run_access(1'b1, 1'b0, `MP_F3_LBU, pick_addr(10 + o, o), '0, 5'(o + 14));
        end
        for (int o = 0; o < 4; o += 2) begin
            run_access(1'b1, 1'b0, `MP_F3_LH, pick_addr(14, o), '0, 5'd18);
            run_access(1'b1, 1'b0, `MP_F3_LHU, pick_addr(15, o), '0, 5'd19);
        end
        run_access(1'b1, 1'b0, `MP_F3_LW, pick_addr(11, 0), '0, 5'd20);
        run_access(1'b1, 1'b0, `MP_F3_LW, pick_addr(9, 0), '0, 5'd21);   // word stored above
    endtask

    task automatic flush_drops_item();
        @(posedge clk);
        drive_item(1'b1, 1'b0, `MP_F3_LW, pick_addr(12, 0), '0, 5'd22);
        flush_i <= 1'b1;
        @(posedge clk);
        issue_i <= 1'b0;
        flush_i <= 1'b0;
        exp_order++;                                // number is used up by the flushed item
        @(negedge clk);
        mask_equal("dmem_rmask_o", dmem_rmask_o, 4'b0000);
        mask_equal("dmem_wmask_o", dmem_wmask_o, 4'b0000);
        @(negedge clk);
        bit_equal("wb_valid_o", wb_valid_o, 1'b0);
        run_access(1'b0, 1'b1, `MP_F3_SB, pick_addr(5, 1), rand_bits(32), 5'd23);
    endtask

    task automatic stall_holds_outputs();
        mem_pipe_pkg::word_t ax;
        mem_pipe_pkg::word_t ay;
        ax = pick_addr(13, 0);
        ay = pick_addr(14, 2);
        @(posedge clk);
        drive_item(1'b1, 1'b0, `MP_F3_LW, ax, '0, 5'd24);
        @(posedge clk);
        drive_item(1'b1, 1'b0, `MP_F3_LHU, ay, '0, 5'd25);   // back to back
        @(posedge clk);
        advance_i <= 1'b0;
        drive_item(1'b0, 1'b1, `MP_F3_SW, pick_addr(2, 0), rand_bits(32), 5'd26);
        repeat (4) begin
            @(negedge clk);
            bit_equal("wb_valid_o", wb_valid_o, 1'b1);
            order_equal("wb_order_o", wb_order_o, exp_order);
            word_equal("wb_data_o", wb_data_o, mem[13]);
            word_equal("dmem_addr_o", dmem_addr_o, {ay[31:2], 2'b00});
            mask_equal("dmem_rmask_o", dmem_rmask_o, 4'b1100);
            mask_equal("dmem_wmask_o", dmem_wmask_o, 4'b0000);
        end
        @(posedge clk);
        advance_i <= 1'b1;
        issue_i   <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        order_equal("wb_order_o", wb_order_o, exp_order + 64'd1);
        word_equal("wb_data_o", wb_data_o, extend_load(mem[14], `MP_F3_LHU, 2'd2));
        mask_equal("dmem_rmask_o", dmem_rmask_o, 4'b0000);  // stalled store was not taken
        mask_equal("dmem_wmask_o", dmem_wmask_o, 4'b0000);
        exp_order = exp_order + 64'd2;
    endtask

    task automatic bad_funct3_traps();
        run_access(1'b1, 1'b0, 3'b011, pick_addr(4, 0), '0, 5'd27);
        run_access(1'b0, 1'b1, 3'b101, pick_addr(4, 1), rand_bits(32), 5'd28);
    endtask

    initial begin
        rst          <= 1'b1;
        advance_i    <= 1'b1;
        flush_i      <= 1'b0;
        issue_i      <= 1'b0;
        is_load_i    <= 1'b0;
        is_store_i   <= 1'b0;
        funct3_i     <= '0;
        addr_i       <= '0;
        store_data_i <= '0;
        rd_i         <= '0;
        mismatches = 0;
        failures   = 0;
        exp_order  = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        bit_equal("wb_valid_o", wb_valid_o, 1'b0);
        mask_equal("dmem_rmask_o", dmem_rmask_o, 4'b0000);
        mask_equal("dmem_wmask_o", dmem_wmask_o, 4'b0000);
        stores_at_offsets();
        loads_with_extension();
        flush_drops_item();
        stall_holds_outputs();
        bad_funct3_traps();
        @(negedge clk);
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #((CYCLES + 50) * 40);
        $display("Error: watchdog expired before the tests finished");
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire
